// ==== filelist.f ====
+incdir+include
logic/rr_pkg.sv
logic/retire_if.sv
logic/free_list.sv
logic/rename_map_table.sv
logic/arch_map_table.sv
logic/reorder_buffer.sv
logic/rename_retire_top.sv
tb/tb_rename_retire.sv

// ==== Bender.yml ====
package:
  name: rename_retire

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/rr_pkg.sv
      - logic/retire_if.sv
      - logic/free_list.sv
      - logic/rename_map_table.sv
      - logic/arch_map_table.sv
      - logic/reorder_buffer.sv
      - logic/rename_retire_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_rename_retire.sv

// ==== tb/tb_rename_retire.sv ====
// --------------------
// Rename and retire testbench
// Directed tests checked against a model of maps, free list and buffer
// --------------------
`timescale 1ns/1ns
`default_nettype none
`include "rr_settings.svh"

module tb_rename_retire;

    localparam int ROB_NUM = `RR_ROB_ENTRY_NUM;
    localparam int FL_NUM = `RR_PHY_REG_NUM - `RR_ARCH_REG_NUM;
    localparam int WAIT_LIMIT = 20;

    // Model view of one buffer entry
    typedef struct packed {
        rr_pkg::rob_idx_t idx;
        rr_pkg::arch_reg_t arch_reg;
        rr_pkg::phy_tag_t tag;
        rr_pkg::phy_tag_t tag_old;
        logic br_predict;
        logic br_result;
        logic complete;
    } entry_t;

    logic clk_i;
    logic rst_i;
    logic [`RR_DP_NUM-1:0] dp_valid_i;
    rr_pkg::arch_reg_t [`RR_DP_NUM-1:0] dp_arch_reg_i;
    logic [`RR_DP_NUM-1:0][`RR_PC_WIDTH-1:0] dp_pc_i;
    logic [`RR_DP_NUM-1:0] dp_br_predict_i;
    rr_pkg::rob_idx_t [`RR_DP_NUM-1:0] dp_rob_idx_o;
    rr_pkg::phy_tag_t [`RR_DP_NUM-1:0] dp_tag_o;
    rr_pkg::phy_tag_t [`RR_DP_NUM-1:0] dp_tag_old_o;
    logic [`RR_CDB_NUM-1:0] cdb_valid_i;
    rr_pkg::rob_idx_t [`RR_CDB_NUM-1:0] cdb_rob_idx_i;
    logic [`RR_CDB_NUM-1:0] cdb_br_result_i;
    logic exception_i;
    logic [`RR_RT_NUM-1:0] retire_valid_o;
    rr_pkg::arch_reg_t [`RR_RT_NUM-1:0] retire_arch_reg_o;
    rr_pkg::phy_tag_t [`RR_RT_NUM-1:0] retire_tag_o;
    logic [$clog2(`RR_RT_NUM+1)-1:0] credit_return_o;
    logic flush_o;

    // --------------------
    // Reference model state
    // --------------------
    rr_pkg::phy_tag_t spec_map [`RR_ARCH_REG_NUM];
    rr_pkg::phy_tag_t cmt_map [`RR_ARCH_REG_NUM];
    rr_pkg::phy_tag_t fl_m [FL_NUM];
    int fl_rd;
    int fl_wr;
    int fl_cmt;
    int tail_m;
    int credits;
    int alloc_cnt;
    entry_t rob_m [$];
    // Old tags in the order they were handed back
    rr_pkg::phy_tag_t recycled_q [$];

    int err_cnt = 0;
    int check_cnt = 0;
    int test_cnt = 0;
    int err_at_start = 0;
    int pc_next = 0;
    string cur_test;

    rename_retire_top UUT (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .dp_valid_i        (dp_valid_i),
        .dp_arch_reg_i     (dp_arch_reg_i),
        .dp_pc_i           (dp_pc_i),
        .dp_br_predict_i   (dp_br_predict_i),
        .dp_rob_idx_o      (dp_rob_idx_o),
        .dp_tag_o          (dp_tag_o),
        .dp_tag_old_o      (dp_tag_old_o),
        .cdb_valid_i       (cdb_valid_i),
        .cdb_rob_idx_i     (cdb_rob_idx_i),
        .cdb_br_result_i   (cdb_br_result_i),
        .exception_i       (exception_i),
        .retire_valid_o    (retire_valid_o),
        .retire_arch_reg_o (retire_arch_reg_o),
        .retire_tag_o      (retire_tag_o),
        .credit_return_o   (credit_return_o),
        .flush_o           (flush_o)
    );

    // 8 ns period
    always begin
        #4 clk_i = ~clk_i;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            $display("MISMATCH %s %s: expected %0d actual %0d",
                     cur_test, what, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_at_start = err_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("test %-16s %s", cur_test, (err_cnt == err_at_start) ? "passed" : "failed");
    endtask

    function automatic rr_pkg::arch_reg_t rand_reg();
        return rr_pkg::arch_reg_t'($urandom % `RR_ARCH_REG_NUM);
    endfunction

    task automatic drive_idle();
        dp_valid_i = '0;
        dp_arch_reg_i = '0;
        dp_pc_i = '0;
        dp_br_predict_i = '0;
        cdb_valid_i = '0;
        cdb_rob_idx_i = '0;
        cdb_br_result_i = '0;
        exception_i = 1'b0;
    endtask

    task automatic model_reset();
        for (int i = 0; i < `RR_ARCH_REG_NUM; i++) begin
            spec_map[i] = rr_pkg::phy_tag_t'(i);
            cmt_map[i] = rr_pkg::phy_tag_t'(i);
        end
        // Tags above the identity mapping, in order
        for (int i = 0; i < FL_NUM; i++) begin
            fl_m[i] = rr_pkg::phy_tag_t'(`RR_ARCH_REG_NUM + i);
        end
        fl_rd = 0;
        fl_wr = 0;
        fl_cmt = 0;
        tail_m = 0;
        credits = ROB_NUM;
        alloc_cnt = 0;
        rob_m.delete();
        recycled_q.delete();
    endtask

    task automatic set_dispatch(input int slot, input rr_pkg::arch_reg_t reg_idx,
                                input logic predict);
        dp_valid_i[slot] = 1'b1;
        dp_arch_reg_i[slot] = reg_idx;
        dp_pc_i[slot] = pc_next;
        dp_br_predict_i[slot] = predict;
        pc_next += 4;
    endtask

    task automatic set_cdb(input int ch, input rr_pkg::rob_idx_t idx, input logic result);
        cdb_valid_i[ch] = 1'b1;
        cdb_rob_idx_i[ch] = idx;
        cdb_br_result_i[ch] = result;
    endtask

    // --------------------
    // One cycle: check outputs, clock, update model
    // --------------------
    task automatic tick();
        logic exc;
        logic flushing;
        int n_rt;
        int n_dp;
        rr_pkg::phy_tag_t exp_tag [`RR_DP_NUM];
        rr_pkg::phy_tag_t exp_old [`RR_DP_NUM];
        entry_t e;
        #1;
        exc = exception_i;
        // Completed run from the oldest entry, cut after a mispredict
        n_rt = 0;
        flushing = 1'b0;
        if (!exc) begin
            while (n_rt < `RR_RT_NUM && n_rt < rob_m.size() && !flushing
                   && rob_m[n_rt].complete) begin
                flushing = rob_m[n_rt].br_result != rob_m[n_rt].br_predict;
                n_rt++;
            end
        end
        for (int k = 0; k < `RR_RT_NUM; k++) begin
            check("retire valid", k < n_rt, retire_valid_o[k]);
            if (k < n_rt) begin
                check("retire arch reg", rob_m[k].arch_reg, retire_arch_reg_o[k]);
                check("retire tag", rob_m[k].tag, retire_tag_o[k]);
            end
        end
        check("credit return", n_rt, credit_return_o);
        check("flush", flushing, flush_o);
        // Free list head and speculative map, with same-cycle bypass
        n_dp = 0;
        for (int k = 0; k < `RR_DP_NUM; k++) begin
            exp_tag[k] = fl_m[(fl_rd + k) % FL_NUM];
            exp_old[k] = spec_map[dp_arch_reg_i[k]];
            for (int j = 0; j < k; j++) begin
                if (dp_valid_i[j] && dp_arch_reg_i[j] == dp_arch_reg_i[k]) begin
                    exp_old[k] = exp_tag[j];
                end
            end
            if (dp_valid_i[k]) begin
                n_dp++;
                check("dispatch index", (tail_m + k) % ROB_NUM, dp_rob_idx_o[k]);
                check("dispatch tag", exp_tag[k], dp_tag_o[k]);
                check("dispatch old tag", exp_old[k], dp_tag_old_o[k]);
            end
        end
        if (n_dp > credits) begin
            $display("ERROR %s: dispatched %0d slots with only %0d credits",
                     cur_test, n_dp, credits);
            err_cnt++;
        end
        @(posedge clk_i);
        for (int k = 0; k < n_rt; k++) begin
            e = rob_m.pop_front();
            cmt_map[e.arch_reg] = e.tag;
            fl_m[fl_wr] = e.tag_old;
            fl_wr = (fl_wr + 1) % FL_NUM;
            fl_cmt = (fl_cmt + 1) % FL_NUM;
            recycled_q.push_back(e.tag_old);
        end
        credits += n_rt;
        if (flushing || exc) begin
            // Squash all, back to committed state
            rob_m.delete();
            spec_map = cmt_map;
            fl_rd = fl_cmt;
            tail_m = 0;
            credits = ROB_NUM;
        end else begin
            for (int c = 0; c < `RR_CDB_NUM; c++) begin
                if (cdb_valid_i[c]) begin
                    foreach (rob_m[i]) begin
                        if (rob_m[i].idx == cdb_rob_idx_i[c]) begin
                            rob_m[i].complete = 1'b1;
                            rob_m[i].br_result = cdb_br_result_i[c];
                        end
                    end
                end
            end
            for (int k = 0; k < `RR_DP_NUM; k++) begin
                if (dp_valid_i[k]) begin
                    e = '{idx: rr_pkg::rob_idx_t'(tail_m), arch_reg: dp_arch_reg_i[k],
                          tag: exp_tag[k], tag_old: exp_old[k],
                          br_predict: dp_br_predict_i[k], br_result: dp_br_predict_i[k],
                          complete: 1'b0};
                    rob_m.push_back(e);
                    spec_map[dp_arch_reg_i[k]] = exp_tag[k];
                    fl_rd = (fl_rd + 1) % FL_NUM;
                    tail_m = (tail_m + 1) % ROB_NUM;
                    credits--;
                    alloc_cnt++;
                end
            end
        end
        #1;
        drive_idle();
    endtask

    task automatic wait_retire();
        int n;
        n = 0;
        while (!retire_valid_o[0] && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (!retire_valid_o[0]) begin
            $display("ERROR %s: nothing retired within %0d cycles", cur_test, WAIT_LIMIT);
            err_cnt++;
        end
    endtask

    // Complete everything in flight with its predicted outcome, then retire it all
    task automatic complete_and_drain();
        entry_t pend [$];
        entry_t e;
        int n;
        foreach (rob_m[i]) begin
            if (!rob_m[i].complete) begin
                pend.push_back(rob_m[i]);
            end
        end
        while (pend.size() > 0) begin
            e = pend.pop_front();
            set_cdb(0, e.idx, e.br_predict);
            if (pend.size() > 0) begin
                e = pend.pop_front();
                set_cdb(1, e.idx, e.br_predict);
            end
            tick();
        end
        n = 0;
        while (rob_m.size() > 0 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (rob_m.size() > 0) begin
            $display("ERROR %s: entries still in flight after %0d cycles", cur_test, n);
            err_cnt++;
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_dispatch();
        rr_pkg::arch_reg_t r0;
        rr_pkg::arch_reg_t r1;
        begin_test("reset_dispatch");
        check("retire valid", 0, retire_valid_o);
        check("flush", 0, flush_o);
        check("credit return", 0, credit_return_o);
        r0 = rand_reg();
        // Different register, no bypass
        r1 = r0 + 1'b1;
        set_dispatch(0, r0, 1'b0);
        set_dispatch(1, r1, 1'b0);
        #1;
        check("first tag", 8, dp_tag_o[0]);
        check("second tag", 9, dp_tag_o[1]);
        check("first index", 0, dp_rob_idx_o[0]);
        check("second index", 1, dp_rob_idx_o[1]);
        check("first old tag", r0, dp_tag_old_o[0]);
        check("second old tag", r1, dp_tag_old_o[1]);
        tick();
        end_test();
    endtask

    task automatic test_ordered_retire();
        begin_test("ordered_retire");
        set_dispatch(0, rand_reg(), 1'b0);
        set_dispatch(1, rand_reg(), 1'b0);
        tick();
        // Youngest first, head last
        set_cdb(0, rob_m[3].idx, 1'b0);
        set_cdb(1, rob_m[2].idx, 1'b0);
        tick();
        check("retire before head", 0, retire_valid_o);
        set_cdb(0, rob_m[1].idx, 1'b0);
        tick();
        check("retire before head", 0, retire_valid_o);
        set_cdb(0, rob_m[0].idx, 1'b0);
        tick();
        wait_retire();
        check("first retire pair", 2'b11, retire_valid_o);
        check("first credit return", 2, credit_return_o);
        tick();
        check("second retire pair", 2'b11, retire_valid_o);
        check("second credit return", 2, credit_return_o);
        tick();
        check("retire when empty", 0, retire_valid_o);
        end_test();
    endtask

    task automatic test_bypass();
        rr_pkg::arch_reg_t r;
        begin_test("rename_bypass");
        r = rand_reg();
        set_dispatch(0, r, 1'b0);
        set_dispatch(1, r, 1'b0);
        #1;
        check("slot 0 old tag", spec_map[r], dp_tag_old_o[0]);
        check("slot 1 old tag", fl_m[fl_rd], dp_tag_old_o[1]);
        tick();
        complete_and_drain();
        end_test();
    endtask

    task automatic test_recycle();
        begin_test("free_recycle");
        // Last two of the initial tags
        set_dispatch(0, rand_reg(), 1'b0);
        set_dispatch(1, rand_reg(), 1'b0);
        tick();
        complete_and_drain();
        // From here tags come back in retire order
        for (int p = 0; p < 2; p++) begin
            set_dispatch(0, rand_reg(), 1'b0);
            set_dispatch(1, rand_reg(), 1'b0);
            #1;
            for (int k = 0; k < `RR_DP_NUM; k++) begin
                check("recycled tag", recycled_q[alloc_cnt - FL_NUM + k], dp_tag_o[k]);
            end
            tick();
        end
        complete_and_drain();
        end_test();
    endtask

    task automatic test_mispredict();
        rr_pkg::arch_reg_t r;
        begin_test("mispredict");
        // Older pair holds the branch, predicted taken
        set_dispatch(0, rand_reg(), 1'b0);
        set_dispatch(1, rand_reg(), 1'b1);
        tick();
        // Younger pair renames r, to be undone by the flush
        r = rand_reg();
        set_dispatch(0, rand_reg(), 1'b0);
        set_dispatch(1, r, 1'b0);
        tick();
        // Younger pair completes first
        set_cdb(0, rob_m[2].idx, 1'b0);
        set_cdb(1, rob_m[3].idx, 1'b0);
        tick();
        // Branch resolves not taken
        set_cdb(0, rob_m[0].idx, 1'b0);
        set_cdb(1, rob_m[1].idx, 1'b0);
        tick();
        wait_retire();
        check("flush pulse", 1, flush_o);
        check("branch retire count", 2, credit_return_o);
        tick();
        for (int i = 0; i < 3; i++) begin
            check("younger retire", 0, retire_valid_o);
            check("flush after pulse", 0, flush_o);
            tick();
        end
        // Restart from committed state
        set_dispatch(0, r, 1'b0);
        #1;
        check("index after flush", 0, dp_rob_idx_o[0]);
        check("old tag after flush", cmt_map[r], dp_tag_old_o[0]);
        check("new tag after flush", fl_m[fl_cmt], dp_tag_o[0]);
        tick();
        complete_and_drain();
        end_test();
    endtask

    task automatic test_exception();
        rr_pkg::arch_reg_t r;
        begin_test("exception");
        // Head renames r, squashed below
        r = rand_reg();
        set_dispatch(0, r, 1'b0);
        set_dispatch(1, rand_reg(), 1'b0);
        tick();
        set_cdb(0, rob_m[0].idx, 1'b0);
        set_cdb(1, rob_m[1].idx, 1'b0);
        tick();
        // Head is ready, exception wins
        exception_i = 1'b1;
        #1;
        check("retire under exception", 0, retire_valid_o);
        check("credit under exception", 0, credit_return_o);
        check("flush under exception", 0, flush_o);
        tick();
        check("retire after exception", 0, retire_valid_o);
        set_dispatch(0, r, 1'b0);
        set_dispatch(1, r + 1'b1, 1'b0);
        #1;
        check("old tag after exception", cmt_map[r], dp_tag_old_o[0]);
        check("new tag after exception", fl_m[fl_cmt], dp_tag_o[0]);
        tick();
        complete_and_drain();
        end_test();
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        void'($urandom(62385));
        clk_i = 1'b0;
        rst_i = 1'b1;
        drive_idle();
        model_reset();
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        test_reset_dispatch();
        test_ordered_retire();
        test_bypass();
        test_recycle();
        test_mispredict();
        test_exception();
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Hard stop if a test never returns
    initial begin
        #100000;
        $display("Run stopped at the time limit before all tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/rename_retire_top.sv ====
// --------------------
// Rename and retire top
// Free list, both map tables and the reorder buffer
// --------------------
`timescale 1ns/1ns
`default_nettype none
`include "rr_settings.svh"

module rename_retire_top (
    input  wire logic clk_i,
    input  wire logic rst_i,
    // Dispatch
    input  wire logic [`RR_DP_NUM-1:0] dp_valid_i,
    input  rr_pkg::arch_reg_t [`RR_DP_NUM-1:0] dp_arch_reg_i,
    input  wire logic [`RR_DP_NUM-1:0][`RR_PC_WIDTH-1:0] dp_pc_i,
    input  wire logic [`RR_DP_NUM-1:0] dp_br_predict_i,
    output rr_pkg::rob_idx_t [`RR_DP_NUM-1:0] dp_rob_idx_o,
    output rr_pkg::phy_tag_t [`RR_DP_NUM-1:0] dp_tag_o,
    output rr_pkg::phy_tag_t [`RR_DP_NUM-1:0] dp_tag_old_o,
    // Completion
    input  wire logic [`RR_CDB_NUM-1:0] cdb_valid_i,
    input  rr_pkg::rob_idx_t [`RR_CDB_NUM-1:0] cdb_rob_idx_i,
    input  wire logic [`RR_CDB_NUM-1:0] cdb_br_result_i,
    input  wire logic exception_i,
    // Retire
    output logic [`RR_RT_NUM-1:0] retire_valid_o,
    output rr_pkg::arch_reg_t [`RR_RT_NUM-1:0] retire_arch_reg_o,
    output rr_pkg::phy_tag_t [`RR_RT_NUM-1:0] retire_tag_o,
    output logic [$clog2(`RR_RT_NUM+1)-1:0] credit_return_o,
    output logic flush_o
);

    rr_pkg::cdb_t [`RR_CDB_NUM-1:0] cdb;
    rr_pkg::phy_tag_t [`RR_ARCH_REG_NUM-1:0] arch_map;

    retire_if rt ();

    // Bundle each completion channel
    always_comb begin
        for (int c = 0; c < `RR_CDB_NUM; c++) begin
            cdb[c].valid = cdb_valid_i[c];
            cdb[c].rob_idx = cdb_rob_idx_i[c];
            cdb[c].br_result = cdb_br_result_i[c];
        end
    end

    // --------------------
    // Rename
    // --------------------
    free_list u_free_list (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .alloc_i     (dp_valid_i),
        .flush_i     (flush_o),
        .exception_i (exception_i),
        .alloc_tag_o (dp_tag_o),
        .rt          (rt.fl)
    );

    rename_map_table u_rename_map_table (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .dp_valid_i    (dp_valid_i),
        .dp_arch_reg_i (dp_arch_reg_i),
        .alloc_tag_i   (dp_tag_o),
        .arch_map_i    (arch_map),
        .flush_i       (flush_o),
        .exception_i   (exception_i),
        .tag_old_o     (dp_tag_old_o)
    );

    // --------------------
    // Track and retire
    // --------------------
    reorder_buffer u_reorder_buffer (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .dp_valid_i      (dp_valid_i),
        .dp_arch_reg_i   (dp_arch_reg_i),
        .dp_pc_i         (dp_pc_i),
        .dp_br_predict_i (dp_br_predict_i),
        .tag_i           (dp_tag_o),
        .tag_old_i       (dp_tag_old_o),
        .dp_rob_idx_o    (dp_rob_idx_o),
        .cdb_i           (cdb),
        .exception_i     (exception_i),
        .credit_return_o (credit_return_o),
        .flush_o         (flush_o),
        .rt              (rt.rob)
    );

    arch_map_table u_arch_map_table (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .arch_map_o (arch_map),
        .rt         (rt.amt)
    );

    // Retire slots out to the core
    assign retire_valid_o = rt.valid;
    assign retire_arch_reg_o = rt.arch_reg;
    assign retire_tag_o = rt.tag;

endmodule

`default_nettype wire

// ==== logic/reorder_buffer.sv ====
// --------------------
// Reorder buffer
// Circular buffer, in-order retire of up to two entries,
// mispredict flush and credit return
// --------------------
`timescale 1ns/1ns
`default_nettype none
`include "rr_settings.svh"

module reorder_buffer (
    input  wire logic clk_i,
    input  wire logic rst_i,
    // Dispatch
    input  wire logic [`RR_DP_NUM-1:0] dp_valid_i,
    input  rr_pkg::arch_reg_t [`RR_DP_NUM-1:0] dp_arch_reg_i,
    input  wire logic [`RR_DP_NUM-1:0][`RR_PC_WIDTH-1:0] dp_pc_i,
    input  wire logic [`RR_DP_NUM-1:0] dp_br_predict_i,
    input  rr_pkg::phy_tag_t [`RR_DP_NUM-1:0] tag_i,
    input  rr_pkg::phy_tag_t [`RR_DP_NUM-1:0] tag_old_i,
    output rr_pkg::rob_idx_t [`RR_DP_NUM-1:0] dp_rob_idx_o,
    // Completion
    input  rr_pkg::cdb_t [`RR_CDB_NUM-1:0] cdb_i,
    input  wire logic exception_i,
    // Retire
    output logic [$clog2(`RR_RT_NUM+1)-1:0] credit_return_o,
    output logic flush_o,
    retire_if.rob rt
);

    rr_pkg::rob_entry_t rob_q [`RR_ROB_ENTRY_NUM];
    rr_pkg::rob_idx_t head_q;
    rr_pkg::rob_idx_t tail_q;

    rr_pkg::dp_t [`RR_DP_NUM-1:0] dp_slot;
    rr_pkg::rob_idx_t dp_cnt;
    logic [`RR_RT_NUM-1:0] rt_valid;
    logic [`RR_RT_NUM-1:0] rt_mispredict;

    // --------------------
    // Dispatch side
    // --------------------
    always_comb begin
        dp_cnt = '0;
        for (int k = 0; k < `RR_DP_NUM; k++) begin
            // Consecutive indices from the tail
            dp_rob_idx_o[k] = rr_pkg::rob_idx_t'(tail_q + k);
            dp_slot[k].pc = dp_pc_i[k];
            dp_slot[k].arch_reg = dp_arch_reg_i[k];
            dp_slot[k].tag = tag_i[k];
            dp_slot[k].tag_old = tag_old_i[k];
            dp_slot[k].br_predict = dp_br_predict_i[k];
            if (dp_valid_i[k]) begin
                dp_cnt = dp_cnt + 1'b1;
            end
        end
    end

    // --------------------
    // Retire select
    // --------------------
    // Contiguous completed run from head, cut after a mispredict
    always_comb begin
        rr_pkg::rob_idx_t idx;
        logic older_ok;
        older_ok = 1'b1;
        credit_return_o = '0;
        for (int k = 0; k < `RR_RT_NUM; k++) begin
            idx = rr_pkg::rob_idx_t'(head_q + k);
            // Exception blocks any retire this cycle
            rt_valid[k] = older_ok & rob_q[idx].valid & rob_q[idx].complete & ~exception_i;
            rt_mispredict[k] = rob_q[idx].br_predict != rob_q[idx].br_result;
            // Younger slots wait behind a mispredicted branch
            older_ok = rt_valid[k] & ~rt_mispredict[k];
            if (rt_valid[k]) begin
                credit_return_o = credit_return_o + 1'b1;
            end
            rt.valid[k] = rt_valid[k];
            rt.arch_reg[k] = rob_q[idx].arch_reg;
            rt.tag[k] = rob_q[idx].tag;
            rt.tag_old[k] = rob_q[idx].tag_old;
        end
        // Branch itself retires, everything younger goes
        flush_o = |(rt_valid & rt_mispredict);
    end

    // --------------------
    // Entry and pointer update
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_o || exception_i) begin
            // Squash all, payload left as is
            head_q <= '0;
            tail_q <= '0;
            for (int i = 0; i < `RR_ROB_ENTRY_NUM; i++) begin
                rob_q[i].valid <= 1'b0;
                rob_q[i].complete <= 1'b0;
            end
        end else begin
            head_q <= head_q + rr_pkg::rob_idx_t'(credit_return_o);
            tail_q <= tail_q + dp_cnt;

            // Free retired entries
            for (int k = 0; k < `RR_RT_NUM; k++) begin
                if (rt_valid[k]) begin
                    rob_q[rr_pkg::rob_idx_t'(head_q + k)].valid <= 1'b0;
                    rob_q[rr_pkg::rob_idx_t'(head_q + k)].complete <= 1'b0;
                end
            end

            // Mark completions with the branch outcome
            for (int c = 0; c < `RR_CDB_NUM; c++) begin
                if (cdb_i[c].valid) begin
                    rob_q[cdb_i[c].rob_idx].complete <= 1'b1;
                    rob_q[cdb_i[c].rob_idx].br_result <= cdb_i[c].br_result;
                end
            end

            // New entries at the tail, written last so a reused slot wins
            for (int k = 0; k < `RR_DP_NUM; k++) begin
                if (dp_valid_i[k]) begin
                    rob_q[rr_pkg::rob_idx_t'(tail_q + k)] <= '{
                        valid: 1'b1,
                        complete: 1'b0,
                        pc: dp_slot[k].pc,
                        arch_reg: dp_slot[k].arch_reg,
                        tag: dp_slot[k].tag,
                        tag_old: dp_slot[k].tag_old,
                        br_predict: dp_slot[k].br_predict,
                        // Not a mispredict until resolved
                        br_result: dp_slot[k].br_predict
                    };
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/arch_map_table.sv ====
// --------------------
// Architectural map table
// Committed mapping, written at retire
// --------------------
`timescale 1ns/1ns
`default_nettype none
`include "rr_settings.svh"

module arch_map_table (
    input  wire logic clk_i,
    input  wire logic rst_i,
    output rr_pkg::phy_tag_t [`RR_ARCH_REG_NUM-1:0] arch_map_o,
    retire_if.amt rt
);

    rr_pkg::phy_tag_t [`RR_ARCH_REG_NUM-1:0] map_q;
    rr_pkg::phy_tag_t [`RR_ARCH_REG_NUM-1:0] map_next;

    // Apply retires in slot order, later slot wins
    always_comb begin
        map_next = map_q;
        for (int k = 0; k < `RR_RT_NUM; k++) begin
            if (rt.valid[k]) begin
                map_next[rt.arch_reg[k]] = rt.tag[k];
            end
        end
    end

    // Includes this cycle's retires, so a restore keeps the branch
    assign arch_map_o = map_next;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `RR_ARCH_REG_NUM; i++) begin
                map_q[i] <= rr_pkg::phy_tag_t'(i);
            end
        end else begin
            map_q <= map_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rename_map_table.sv ====
// --------------------
// Speculative map table
// Newest tag per register, restored from the arch map on flush
// --------------------
`timescale 1ns/1ns
`default_nettype none
`include "rr_settings.svh"

module rename_map_table (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic [`RR_DP_NUM-1:0] dp_valid_i,
    input  rr_pkg::arch_reg_t [`RR_DP_NUM-1:0] dp_arch_reg_i,
    input  rr_pkg::phy_tag_t [`RR_DP_NUM-1:0] alloc_tag_i,
    input  rr_pkg::phy_tag_t [`RR_ARCH_REG_NUM-1:0] arch_map_i,
    input  wire logic flush_i,
    input  wire logic exception_i,
    output rr_pkg::phy_tag_t [`RR_DP_NUM-1:0] tag_old_o
);

    rr_pkg::phy_tag_t [`RR_ARCH_REG_NUM-1:0] map_q;

    // --------------------
    // Lookup with bypass
    // --------------------
    always_comb begin
        for (int k = 0; k < `RR_DP_NUM; k++) begin
            tag_old_o[k] = map_q[dp_arch_reg_i[k]];
            // Older slot renaming the same register this cycle
            for (int j = 0; j < k; j++) begin
                if (dp_valid_i[j] && (dp_arch_reg_i[j] == dp_arch_reg_i[k])) begin
                    tag_old_o[k] = alloc_tag_i[j];
                end
            end
        end
    end

    // --------------------
    // Update
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Identity mapping
            for (int i = 0; i < `RR_ARCH_REG_NUM; i++) begin
                map_q[i] <= rr_pkg::phy_tag_t'(i);
            end
        end else if (flush_i || exception_i) begin
            // Dispatch in this cycle is dropped
            map_q <= arch_map_i;
        end else begin
            // Later slot wins on a shared register
            for (int k = 0; k < `RR_DP_NUM; k++) begin
                if (dp_valid_i[k]) begin
                    map_q[dp_arch_reg_i[k]] <= alloc_tag_i[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/free_list.sv ====
// --------------------
// Free list
// FIFO of free physical tags with a committed read pointer
// --------------------
`timescale 1ns/1ns
`default_nettype none
`include "rr_settings.svh"

module free_list (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic [`RR_DP_NUM-1:0] alloc_i,
    input  wire logic flush_i,
    input  wire logic exception_i,
    output rr_pkg::phy_tag_t [`RR_DP_NUM-1:0] alloc_tag_o,
    retire_if.fl rt
);

    localparam int FL_NUM = `RR_PHY_REG_NUM - `RR_ARCH_REG_NUM;
    localparam int PTR_W = $clog2(FL_NUM);

    rr_pkg::phy_tag_t fifo_q [FL_NUM];
    logic [PTR_W-1:0] rd_q;
    logic [PTR_W-1:0] wr_q;
    // Read pointer as seen by retired code
    logic [PTR_W-1:0] cmt_q;
    logic [PTR_W-1:0] cmt_next;
    logic [PTR_W-1:0] pop_cnt;
    logic [PTR_W-1:0] push_cnt;

    // Head tags offered to the dispatch slots
    always_comb begin
        pop_cnt = '0;
        push_cnt = '0;
        for (int k = 0; k < `RR_DP_NUM; k++) begin
            alloc_tag_o[k] = fifo_q[PTR_W'(rd_q + k)];
            if (alloc_i[k]) begin
                pop_cnt = pop_cnt + 1'b1;
            end
        end
        for (int k = 0; k < `RR_RT_NUM; k++) begin
            if (rt.valid[k]) begin
                push_cnt = push_cnt + 1'b1;
            end
        end
        // One tag was taken per retired instruction, in order
        cmt_next = cmt_q + push_cnt;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Tags above the identity mapping start free
            for (int i = 0; i < FL_NUM; i++) begin
                fifo_q[i] <= rr_pkg::phy_tag_t'(`RR_ARCH_REG_NUM + i);
            end
            rd_q <= '0;
            wr_q <= '0;
            cmt_q <= '0;
        end else begin
            // Old tags come back at the write side
            for (int k = 0; k < `RR_RT_NUM; k++) begin
                if (rt.valid[k]) begin
                    fifo_q[PTR_W'(wr_q + k)] <= rt.tag_old[k];
                end
            end
            wr_q <= wr_q + push_cnt;
            cmt_q <= cmt_next;
            if (flush_i || exception_i) begin
                // Drop speculative allocations
                rd_q <= cmt_next;
            end else begin
                rd_q <= rd_q + pop_cnt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/retire_if.sv ====
// --------------------
// Retire slot bundle
// Buffer to arch map and free list
// --------------------
`timescale 1ns/1ns
`default_nettype none
`include "rr_settings.svh"

interface retire_if;

    // Per retire slot, slot 0 oldest
    logic [`RR_RT_NUM-1:0] valid;
    rr_pkg::arch_reg_t [`RR_RT_NUM-1:0] arch_reg;
    rr_pkg::phy_tag_t [`RR_RT_NUM-1:0] tag;
    rr_pkg::phy_tag_t [`RR_RT_NUM-1:0] tag_old;

    // Reorder buffer drives everything
    modport rob (output valid, arch_reg, tag, tag_old);
    // Committed map takes the new tags
    modport amt (input valid, arch_reg, tag);
    // Free list takes back the old tags
    modport fl (input valid, tag_old);

endinterface

`default_nettype wire

// ==== logic/rr_pkg.sv ====
// --------------------
// Rename and retire types
// Tags, indices and the buffer entry layout
// --------------------
`default_nettype none
`include "rr_settings.svh"

package rr_pkg;

    // Index types
    typedef logic [$clog2(`RR_ARCH_REG_NUM)-1:0] arch_reg_t;
    typedef logic [$clog2(`RR_PHY_REG_NUM)-1:0] phy_tag_t;
    typedef logic [$clog2(`RR_ROB_ENTRY_NUM)-1:0] rob_idx_t;

    // --------------------
    // Reorder buffer entry
    // --------------------
    typedef struct packed {
        logic valid;
        logic complete;
        logic [`RR_PC_WIDTH-1:0] pc;
        arch_reg_t arch_reg;
        // New tag and the one it replaces
        phy_tag_t tag;
        phy_tag_t tag_old;
        logic br_predict;
        logic br_result;
    } rob_entry_t;

    // One dispatch slot, as written at the tail
    typedef struct packed {
        logic [`RR_PC_WIDTH-1:0] pc;
        arch_reg_t arch_reg;
        phy_tag_t tag;
        phy_tag_t tag_old;
        logic br_predict;
    } dp_t;

    // One completion channel
    typedef struct packed {
        logic valid;
        rob_idx_t rob_idx;
        logic br_result;
    } cdb_t;

endpackage

`default_nettype wire

// ==== include/rr_settings.svh ====
// --------------------
// Rename and retire settings
// Widths and counts shared by the design
// --------------------
`ifndef RR_SETTINGS_SVH
`define RR_SETTINGS_SVH

// Slots per cycle
`define RR_DP_NUM 2
`define RR_RT_NUM 2
`define RR_CDB_NUM 2

// Reorder buffer depth
// Must not exceed physical minus architectural registers
`define RR_ROB_ENTRY_NUM 8

// Register files
`define RR_ARCH_REG_NUM 8
`define RR_PHY_REG_NUM 16

// Program counter
`define RR_PC_WIDTH 32

`endif
